// File: dep_pipe.sv
// execute stage dependency records
module dep_pipe
  import rv_isa_pkg::*;
  import detector_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    reset_i,
  input  dispatch_pkt_t [NUM_SLOTS-1:0]           dispatch_pkt_i,
  output dep_rec_t [DEP_STAGES-1:0][NUM_SLOTS-1:0] dep_stage_o,
  output logic                                    instr_in_pipe_o,
  output logic                                    mem_in_pipe_o
);

  dep_rec_t [NUM_SLOTS-1:0]                 rec_n;
  dep_rec_t [DEP_STAGES-1:0][NUM_SLOTS-1:0] stage_r;

  // one record per slot, all zero when the slot dispatches nothing
  always_comb
  begin
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      rec_n[s] = '0;
      if (dispatch_pkt_i[s].v)
      begin
        rec_n[s].v          = 1'b1;
        rec_n[s].mem_v      = dispatch_pkt_i[s].mem_v;
        rec_n[s].csr_v      = dispatch_pkt_i[s].csr_v;
        rec_n[s].irf_w_v    = dispatch_pkt_i[s].irf_w_v;
        rec_n[s].pipe_class = dispatch_pkt_i[s].pipe_class;
        rec_n[s].rd_addr    = dispatch_pkt_i[s].rd_addr;
      end
    end
  end

  // ex1 takes the new records, older ones move one stage on
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      stage_r <= '0;
    end
    else
    begin
      stage_r[0]              <= rec_n;
      stage_r[DEP_STAGES-1:1] <= stage_r[DEP_STAGES-2:0];
    end
  end

  // summaries for the fence, csr and long-latency rules
  always_comb
  begin
    instr_in_pipe_o = 1'b0;
    mem_in_pipe_o   = 1'b0;
    for (int k = 0; k < DEP_STAGES; k++)
    begin
      for (int s = 0; s < NUM_SLOTS; s++)
      begin
        instr_in_pipe_o = instr_in_pipe_o | stage_r[k][s].v;
        mem_in_pipe_o   = mem_in_pipe_o | stage_r[k][s].mem_v;
      end
    end
  end

  assign dep_stage_o = stage_r;

endmodule

// File: detector_pkg.sv
// hazard detector types
package detector_pkg;
  import rv_isa_pkg::*;

  // ex1, ex2 and ex3 are tracked
  localparam int DEP_STAGES = 3;

  // functional unit that executes an instruction
  typedef enum logic [2:0] {
    PIPE_NONE = 3'd0,
    PIPE_CTL  = 3'd1,
    PIPE_INT  = 3'd2,
    PIPE_AUX  = 3'd3,
    PIPE_EMEM = 3'd4,
    PIPE_FMEM = 3'd5,
    PIPE_MUL  = 3'd6
  } pipe_class_e;

  // issue status of the instruction waiting in one slot
  typedef struct packed {
    logic      irs1_v;
    logic      irs2_v;
    logic      iwb_v;
    logic      fence_v;
    logic      mem_v;
    logic      csr_v;
    logic      long_v;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
  } isd_status_t;

  // instruction leaving the scheduler this cycle
  typedef struct packed {
    logic        v;
    logic        late_iwb_v;
    logic        mem_v;
    logic        csr_v;
    logic        irf_w_v;
    pipe_class_e pipe_class;
    reg_addr_t   rd_addr;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
  } dispatch_pkt_t;

  // what one slot left behind in one execute stage
  typedef struct packed {
    logic        v;
    logic        mem_v;
    logic        csr_v;
    logic        irf_w_v;
    pipe_class_e pipe_class;
    reg_addr_t   rd_addr;
  } dep_rec_t;

  typedef struct packed {
    logic      dcache_miss;
    opcode_t   opcode;
    reg_addr_t rd_addr;
  } commit_pkt_t;

  typedef struct packed {
    logic      ird_w_v;
    logic      late;
    reg_addr_t rd_addr;
  } wb_pkt_t;

endpackage

// File: flist.f
rv_isa_pkg.sv
detector_pkg.sv
dep_pipe.sv
late_scoreboard.sv
slot_hazard_check.sv
hazard_detector_top.sv
hazard_detector_props.sv
tb_hazard_detector.sv

// File: hazard_detector_props.sv
// hazard detector properties
module hazard_detector_props
  import rv_isa_pkg::*;
  import detector_pkg::*;
(
  input logic                          clk_i,
  input logic                          reset_i,
  input dispatch_pkt_t [NUM_SLOTS-1:0] dispatch_pkt_i,
  input logic                          cmd_full_i,
  input logic                          credits_full_i,
  input logic                          credits_empty_i,
  input logic                          idiv_ready_i,
  input logic                          mem_ready_i,
  input logic                          ptw_busy_i,
  input logic [NUM_SLOTS-1:0]          dispatch_v_o,
  input logic                          interrupt_v_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic quiet;

  // nothing that could stall an empty pipeline
  assign quiet = ~ptw_busy_i & ~cmd_full_i & mem_ready_i & idiv_ready_i
                 & credits_empty_i & ~credits_full_i;

  a_irq_masked: assert property (@(posedge clk_i) disable iff (reset_i)
                                 ptw_busy_i |-> !interrupt_v_o)
    else $error("interrupt raised while the page walker is busy");

  a_idle_after_reset: assert property (@(posedge clk_i)
      ($fell(reset_i) && quiet && !dispatch_pkt_i[0].v && !dispatch_pkt_i[1].v)
      |-> (&dispatch_v_o))
    else $error("dispatch stalled in the first idle cycle after reset");

endmodule

bind hazard_detector_top hazard_detector_props u_props (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .dispatch_pkt_i  (dispatch_pkt_i),
  .cmd_full_i      (cmd_full_i),
  .credits_full_i  (credits_full_i),
  .credits_empty_i (credits_empty_i),
  .idiv_ready_i    (idiv_ready_i),
  .mem_ready_i     (mem_ready_i),
  .ptw_busy_i      (ptw_busy_i),
  .dispatch_v_o    (dispatch_v_o),
  .interrupt_v_o   (interrupt_v_o)
);

// File: hazard_detector_top.sv
// dual-issue integer hazard detector
module hazard_detector_top
  import rv_isa_pkg::*;
  import detector_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  isd_status_t [NUM_SLOTS-1:0]   isd_status_i,
  input  dispatch_pkt_t [NUM_SLOTS-1:0] dispatch_pkt_i,
  input  commit_pkt_t                   commit_pkt_i,
  input  wb_pkt_t                       iwb_pkt_i,
  input  logic                          cmd_full_i,
  input  logic                          credits_full_i,
  input  logic                          credits_empty_i,
  input  logic                          idiv_ready_i,
  input  logic                          mem_ready_i,
  input  logic                          ptw_busy_i,
  input  logic                          irq_pending_i,
  output logic [NUM_SLOTS-1:0]          dispatch_v_o,
  output logic                          interrupt_v_o
);

  dep_rec_t [DEP_STAGES-1:0][NUM_SLOTS-1:0] dep_stage;
  logic                                     instr_in_pipe;
  logic                                     mem_in_pipe;
  logic [NUM_SLOTS-1:0][1:0]                rs_busy;
  logic [NUM_SLOTS-1:0]                     rd_busy;

  dep_pipe u_dep_pipe (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .dispatch_pkt_i  (dispatch_pkt_i),
    .dep_stage_o     (dep_stage),
    .instr_in_pipe_o (instr_in_pipe),
    .mem_in_pipe_o   (mem_in_pipe)
  );

  late_scoreboard u_late_scoreboard (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .dispatch_pkt_i (dispatch_pkt_i),
    .commit_pkt_i   (commit_pkt_i),
    .iwb_pkt_i      (iwb_pkt_i),
    .isd_status_i   (isd_status_i),
    .rs_busy_o      (rs_busy),
    .rd_busy_o      (rd_busy)
  );

  // same-cycle dependencies between the two slots are not checked
  for (genvar s = 0; s < NUM_SLOTS; s++)
  begin : g_slot
    slot_hazard_check u_check (
      .isd_status_i    (isd_status_i[s]),
      .dep_stage_i     (dep_stage),
      .instr_in_pipe_i (instr_in_pipe),
      .mem_in_pipe_i   (mem_in_pipe),
      .rs_busy_i       (rs_busy[s]),
      .rd_busy_i       (rd_busy[s]),
      .cmd_full_i      (cmd_full_i),
      .credits_full_i  (credits_full_i),
      .credits_empty_i (credits_empty_i),
      .idiv_ready_i    (idiv_ready_i),
      .mem_ready_i     (mem_ready_i),
      .ptw_busy_i      (ptw_busy_i),
      .dispatch_v_o    (dispatch_v_o[s])
    );
  end

  // no interrupt while a page walk is in progress
  assign interrupt_v_o = irq_pending_i & ~ptw_busy_i;

endmodule

// File: late_scoreboard.sv
// late integer writeback scoreboard
module late_scoreboard
  import rv_isa_pkg::*;
  import detector_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  dispatch_pkt_t [NUM_SLOTS-1:0]      dispatch_pkt_i,
  input  commit_pkt_t                        commit_pkt_i,
  input  wb_pkt_t                            iwb_pkt_i,
  input  isd_status_t [NUM_SLOTS-1:0]        isd_status_i,
  output logic [NUM_SLOTS-1:0][1:0]          rs_busy_o,
  output logic [NUM_SLOTS-1:0]               rd_busy_o
);

  logic [NUM_REGS-1:0]  pending_r;
  logic [NUM_REGS-1:0]  pending_n;
  logic                 commit_score_v;
  logic [NUM_SLOTS-1:0] score_v;
  reg_addr_t            score_rd [NUM_SLOTS];
  logic                 clear_v;

  // a missed load or atomic at commit writes back late as well
  assign commit_score_v = commit_pkt_i.dcache_miss
                          & (commit_pkt_i.opcode inside {OPC_LOAD, OPC_AMO});

  always_comb
  begin
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      score_v[s]  = dispatch_pkt_i[s].v & dispatch_pkt_i[s].late_iwb_v;
      score_rd[s] = dispatch_pkt_i[s].rd_addr;
    end
    // the commit score borrows slot 0's port
    if (commit_score_v)
    begin
      score_v[0]  = 1'b1;
      score_rd[0] = commit_pkt_i.rd_addr;
    end
  end

  assign clear_v = iwb_pkt_i.ird_w_v & iwb_pkt_i.late;

  // clear first so that a score of the same register wins
  always_comb
  begin
    pending_n = pending_r;
    if (clear_v)
    begin
      pending_n[iwb_pkt_i.rd_addr] = 1'b0;
    end
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      if (score_v[s])
      begin
        pending_n[score_rd[s]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pending_r <= '0;
    end
    else
    begin
      pending_r <= pending_n;
    end
  end

  // lookups see the registered table only, no bypass
  always_comb
  begin
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      rs_busy_o[s][0] = pending_r[isd_status_i[s].rs1_addr];
      rs_busy_o[s][1] = pending_r[isd_status_i[s].rs2_addr];
      rd_busy_o[s]    = pending_r[isd_status_i[s].rd_addr];
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the hazard detector testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module tb_hazard_detector -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
  exit 0
fi
exit 1

// File: rv_isa_pkg.sv
// integer ISA constants
package rv_isa_pkg;

  // integer register file
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // major opcode field
  typedef logic [6:0] opcode_t;

  // loads and atomics can miss in the data cache and write back late
  localparam opcode_t OPC_LOAD = 7'b0000011;
  localparam opcode_t OPC_AMO  = 7'b0101111;

  // issue width of the back end
  localparam int NUM_SLOTS = 2;

endpackage

// File: slot_hazard_check.sv
// dispatch decision for one issue slot
module slot_hazard_check
  import rv_isa_pkg::*;
  import detector_pkg::*;
(
  input  isd_status_t                              isd_status_i,
  input  dep_rec_t [DEP_STAGES-1:0][NUM_SLOTS-1:0] dep_stage_i,
  input  logic                                     instr_in_pipe_i,
  input  logic                                     mem_in_pipe_i,
  input  logic [1:0]                               rs_busy_i,
  input  logic                                     rd_busy_i,
  input  logic                                     cmd_full_i,
  input  logic                                     credits_full_i,
  input  logic                                     credits_empty_i,
  input  logic                                     idiv_ready_i,
  input  logic                                     mem_ready_i,
  input  logic                                     ptw_busy_i,
  output logic                                     dispatch_v_o
);

  logic rs1_used;
  logic rs2_used;
  logic data_haz;
  logic sb_haz;
  logic fence_haz;
  logic csr_haz;
  logic long_haz;
  logic credit_haz;
  logic control_haz;
  logic struct_haz;

  // true while a producer of this class has no result yet in that stage
  function automatic logic result_not_ready(input int stage, input pipe_class_e cls);
    logic busy;
    busy = 1'b0;
    if (stage == 0)
    begin
      busy = cls inside {PIPE_AUX, PIPE_MUL, PIPE_EMEM, PIPE_FMEM};
    end
    else if (stage == 1)
    begin
      busy = cls inside {PIPE_FMEM, PIPE_MUL};
    end
    return busy;
  endfunction

  // x0 is never a real dependency
  assign rs1_used = isd_status_i.irs1_v & (isd_status_i.rs1_addr != '0);
  assign rs2_used = isd_status_i.irs2_v & (isd_status_i.rs2_addr != '0);

  // compare against both slots' records in every stage
  always_comb
  begin
    data_haz = 1'b0;
    for (int k = 0; k < DEP_STAGES; k++)
    begin
      for (int s = 0; s < NUM_SLOTS; s++)
      begin
        if (dep_stage_i[k][s].irf_w_v
            && result_not_ready(k, dep_stage_i[k][s].pipe_class))
        begin
          if (rs1_used && (isd_status_i.rs1_addr == dep_stage_i[k][s].rd_addr))
          begin
            data_haz = 1'b1;
          end
          if (rs2_used && (isd_status_i.rs2_addr == dep_stage_i[k][s].rd_addr))
          begin
            data_haz = 1'b1;
          end
        end
      end
    end
  end

  // raw on sources, waw on the destination
  assign sb_haz = (rs1_used & rs_busy_i[0])
                  | (rs2_used & rs_busy_i[1])
                  | (isd_status_i.iwb_v & rd_busy_i);

  // a fence waits for memory to drain completely
  assign fence_haz   = isd_status_i.fence_v
                       & (~credits_empty_i | mem_in_pipe_i | ~mem_ready_i);
  assign credit_haz  = isd_status_i.mem_v & credits_full_i;
  assign csr_haz     = isd_status_i.csr_v & instr_in_pipe_i;
  assign long_haz    = isd_status_i.long_v & instr_in_pipe_i;
  assign control_haz = fence_haz | credit_haz | csr_haz | long_haz;

  assign struct_haz = ptw_busy_i
                      | cmd_full_i
                      | (isd_status_i.mem_v & ~mem_ready_i)
                      | (isd_status_i.long_v & ~idiv_ready_i);

  assign dispatch_v_o = ~(data_haz | sb_haz | control_haz | struct_haz);

endmodule

// File: tb_hazard_detector.sv
// hazard detector testbench
module tb_hazard_detector
  import rv_isa_pkg::*;
  import detector_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 40;
  localparam int DIRECTED_CYCLES = 120;
  localparam int RANDOM_CYCLES   = 400;
  localparam int TIMEOUT_CYCLES  = DIRECTED_CYCLES + RANDOM_CYCLES + 50;

  typedef dep_rec_t [NUM_SLOTS-1:0] rec_pair_t;
  typedef enum int {BLK_CREDITS_PENDING, BLK_CREDITS_FULL, BLK_DIV_BUSY,
                    BLK_PTW_BUSY, BLK_CMD_FULL, BLK_MEM_BUSY} blocker_e;

  logic                          clk_i;
  logic                          reset_i;
  isd_status_t [NUM_SLOTS-1:0]   isd_status;
  dispatch_pkt_t [NUM_SLOTS-1:0] dispatch_pkt;
  commit_pkt_t                   commit_pkt;
  wb_pkt_t                       iwb_pkt;
  logic                          cmd_full;
  logic                          credits_full;
  logic                          credits_empty;
  logic                          idiv_ready;
  logic                          mem_ready;
  logic                          ptw_busy;
  logic                          irq_pending;
  logic [NUM_SLOTS-1:0]          dispatch_v;
  logic                          interrupt_v;

  // model state with entry 0 of the queue as ex1
  rec_pair_t           stage_q[$];
  logic [NUM_REGS-1:0] model_pend;

  int checks;
  int dispatch_errs;
  int irq_errs;
  int directed_errs;
  int cycle_cnt;

  hazard_detector_top dut0 (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .isd_status_i    (isd_status),
    .dispatch_pkt_i  (dispatch_pkt),
    .commit_pkt_i    (commit_pkt),
    .iwb_pkt_i       (iwb_pkt),
    .cmd_full_i      (cmd_full),
    .credits_full_i  (credits_full),
    .credits_empty_i (credits_empty),
    .idiv_ready_i    (idiv_ready),
    .mem_ready_i     (mem_ready),
    .ptw_busy_i      (ptw_busy),
    .irq_pending_i   (irq_pending),
    .dispatch_v_o    (dispatch_v),
    .interrupt_v_o   (interrupt_v)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // cycles after ex1 entry in which the result is still missing
  function automatic int result_latency(input pipe_class_e cls);
    case (cls)
      PIPE_MUL, PIPE_FMEM: return 2;
      PIPE_AUX, PIPE_EMEM: return 1;
      default:             return 0;
    endcase
  endfunction

  function automatic logic reads_reg(input logic used, input reg_addr_t src,
                                     input reg_addr_t dst);
    return used && (src != '0) && (src == dst);
  endfunction

  function automatic logic slot_may_dispatch(input isd_status_t st);
    logic     ok;
    logic     in_flight;
    logic     mem_flight;
    dep_rec_t r;
    ok         = 1'b1;
    in_flight  = 1'b0;
    mem_flight = 1'b0;
    for (int k = 0; k < DEP_STAGES; k++)
    begin
      for (int s = 0; s < NUM_SLOTS; s++)
      begin
        r          = stage_q[k][s];
        in_flight  = in_flight | r.v;
        mem_flight = mem_flight | r.mem_v;
        if (r.irf_w_v && (k < result_latency(r.pipe_class))
            && (reads_reg(st.irs1_v, st.rs1_addr, r.rd_addr)
                || reads_reg(st.irs2_v, st.rs2_addr, r.rd_addr)))
          ok = 1'b0;
      end
    end
    // late writebacks still outstanding
    if (reads_reg(st.irs1_v, st.rs1_addr, st.rs1_addr) && model_pend[st.rs1_addr])
      ok = 1'b0;
    if (reads_reg(st.irs2_v, st.rs2_addr, st.rs2_addr) && model_pend[st.rs2_addr])
      ok = 1'b0;
    if (st.iwb_v && model_pend[st.rd_addr])
      ok = 1'b0;
    if (st.fence_v && (!credits_empty || mem_flight || !mem_ready))
      ok = 1'b0;
    if (st.mem_v && (credits_full || !mem_ready))
      ok = 1'b0;
    if ((st.csr_v || st.long_v) && in_flight)
      ok = 1'b0;
    if ((st.long_v && !idiv_ready) || ptw_busy || cmd_full)
      ok = 1'b0;
    return ok;
  endfunction

  // interrupt in the top bit and one dispatch bit per slot below
  function automatic logic [NUM_SLOTS:0] expected_outputs();
    logic [NUM_SLOTS:0] res;
    for (int s = 0; s < NUM_SLOTS; s++)
      res[s] = slot_may_dispatch(isd_status[s]);
    res[NUM_SLOTS] = irq_pending && !ptw_busy;
    return res;
  endfunction

  task automatic reset_model();
    rec_pair_t zero;
    zero = '0;
    stage_q.delete();
    repeat (DEP_STAGES) stage_q.push_back(zero);
    model_pend = '0;
  endtask

  task automatic update_model();
    rec_pair_t           pair;
    logic [NUM_REGS-1:0] pend;
    pend = model_pend;
    if (iwb_pkt.ird_w_v && iwb_pkt.late)
      pend[iwb_pkt.rd_addr] = 1'b0;
    if (dispatch_pkt[1].v && dispatch_pkt[1].late_iwb_v)
      pend[dispatch_pkt[1].rd_addr] = 1'b1;
    // a missed load or atomic takes slot 0's score
    if (commit_pkt.dcache_miss
        && (commit_pkt.opcode == OPC_LOAD || commit_pkt.opcode == OPC_AMO))
      pend[commit_pkt.rd_addr] = 1'b1;
    else if (dispatch_pkt[0].v && dispatch_pkt[0].late_iwb_v)
      pend[dispatch_pkt[0].rd_addr] = 1'b1;
    model_pend = pend;
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      pair[s] = '0;
      if (dispatch_pkt[s].v)
      begin
        pair[s].v          = 1'b1;
        pair[s].mem_v      = dispatch_pkt[s].mem_v;
        pair[s].csr_v      = dispatch_pkt[s].csr_v;
        pair[s].irf_w_v    = dispatch_pkt[s].irf_w_v;
        pair[s].pipe_class = dispatch_pkt[s].pipe_class;
        pair[s].rd_addr    = dispatch_pkt[s].rd_addr;
      end
    end
    stage_q.push_front(pair);
    void'(stage_q.pop_back());
  endtask

  always @(posedge clk_i)
  begin
    if (reset_i)
      reset_model();
    else
      update_model();
  end

  // outputs are settled just before the next rising edge
  initial
  begin
    logic [NUM_SLOTS:0] exp;
    forever
    begin
      @(posedge clk_i);
      #(CLK_PERIOD - 2);
      if (!reset_i)
      begin
        exp = expected_outputs();
        checks++;
        assert (dispatch_v === exp[NUM_SLOTS-1:0])
        else
        begin
          dispatch_errs++;
          $display("** Error at %0d ns: dispatch_v_o = %b, expected %b",
                   $time, dispatch_v, exp[NUM_SLOTS-1:0]);
        end
        assert (interrupt_v === exp[NUM_SLOTS])
        else
        begin
          irq_errs++;
          $display("** Error at %0d ns: interrupt_v_o = %b, expected %b",
                   $time, interrupt_v, exp[NUM_SLOTS]);
        end
      end
    end
  end

  task automatic finish_run(input logic timed_out);
    int total;
    total = dispatch_errs + irq_errs + directed_errs;
    $display("checks %0d, dispatch errors %0d, interrupt errors %0d, directed errors %0d",
             checks, dispatch_errs, irq_errs, directed_errs);
    if (total == 0 && !timed_out)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    finish_run(1'b1);
  end

  // called right after an edge and expects the slot blocked for the given cycles
  task automatic expect_stall(input int slot, input int cycles);
    logic want;
    for (int i = 0; i <= cycles; i++)
    begin
      want = (i == cycles);
      #(CLK_PERIOD - 2);
      assert (dispatch_v[slot] === want)
      else
      begin
        directed_errs++;
        $display("** Error at %0d ns: dispatch_v_o[%0d] = %b, expected %b",
                 $time, slot, dispatch_v[slot], want);
      end
      @(posedge clk_i);
    end
  endtask

  function automatic logic one_in(input int n);
    return $urandom_range(0, n - 1) == 0;
  endfunction

  function automatic reg_addr_t rand_addr();
    return reg_addr_t'($urandom_range(0, 7));
  endfunction

  function automatic isd_status_t ctl_status(input logic fence, input logic mem,
                                             input logic csr, input logic long_lat);
    isd_status_t st;
    st         = '0;
    st.fence_v = fence;
    st.mem_v   = mem;
    st.csr_v   = csr;
    st.long_v  = long_lat;
    return st;
  endfunction

  task automatic set_blocker(input blocker_e blk, input logic on);
    case (blk)
      BLK_CREDITS_PENDING: credits_empty <= !on;
      BLK_CREDITS_FULL:    credits_full <= on;
      BLK_DIV_BUSY:        idiv_ready <= !on;
      BLK_PTW_BUSY:        ptw_busy <= on;
      BLK_CMD_FULL:        cmd_full <= on;
      default:             mem_ready <= !on;
    endcase
  endtask

  // producer in slot 1 and dependent reader in slot 0
  task automatic producer_blocks_reader(input pipe_class_e cls, input reg_addr_t rd,
                                        input int cycles);
    dispatch_pkt_t p;
    isd_status_t   st;
    p            = '0;
    p.v          = 1'b1;
    p.irf_w_v    = 1'b1;
    p.pipe_class = cls;
    p.rd_addr    = rd;
    st           = '0;
    st.irs2_v    = 1'b1;
    st.rs2_addr  = rd;
    @(posedge clk_i);
    dispatch_pkt[1] <= p;
    @(posedge clk_i);
    dispatch_pkt  <= '0;
    isd_status[0] <= st;
    expect_stall(0, cycles);
    isd_status <= '0;
  endtask

  task automatic late_write_blocks(input logic from_commit, input reg_addr_t rd);
    dispatch_pkt_t p;
    commit_pkt_t   c;
    isd_status_t   st;
    wb_pkt_t       w;
    p = '0;
    c = '0;
    if (from_commit)
    begin
      c.dcache_miss = 1'b1;
      c.opcode      = OPC_LOAD;
      c.rd_addr     = rd;
    end
    else
    begin
      p.v          = 1'b1;
      p.late_iwb_v = 1'b1;
      p.pipe_class = PIPE_EMEM;
      p.rd_addr    = rd;
    end
    st          = '0;
    st.irs1_v   = 1'b1;
    st.rs1_addr = rd;
    st.iwb_v    = 1'b1;
    st.rd_addr  = rd;
    w           = '{ird_w_v: 1'b1, late: 1'b1, rd_addr: rd};
    @(posedge clk_i);
    commit_pkt      <= c;
    dispatch_pkt[0] <= p;
    @(posedge clk_i);
    commit_pkt    <= '0;
    dispatch_pkt  <= '0;
    isd_status[1] <= st;
    repeat (3) @(posedge clk_i);
    iwb_pkt <= w;
    expect_stall(1, 1);
    iwb_pkt    <= '0;
    isd_status <= '0;
  endtask

  task automatic level_holds_slot(input int slot, input isd_status_t st, input blocker_e blk);
    @(posedge clk_i);
    isd_status       <= '0;
    isd_status[slot] <= st;
    set_blocker(blk, 1'b1);
    repeat (2) @(posedge clk_i);
    set_blocker(blk, 1'b0);
    expect_stall(slot, 0);
    isd_status <= '0;
  endtask

  task automatic pipe_drain_holds_slot(input int slot, input isd_status_t st,
                                       input logic mem_op, input int cycles);
    dispatch_pkt_t p;
    p            = '0;
    p.v          = 1'b1;
    p.mem_v      = mem_op;
    p.pipe_class = mem_op ? PIPE_EMEM : PIPE_INT;
    @(posedge clk_i);
    isd_status               <= '0;
    isd_status[slot]         <= st;
    dispatch_pkt[1 - slot]   <= p;
    @(posedge clk_i);
    dispatch_pkt <= '0;
    expect_stall(slot, cycles);
    isd_status <= '0;
  endtask

  task automatic drive_random();
    isd_status_t   st;
    dispatch_pkt_t p;
    commit_pkt_t   c;
    for (int s = 0; s < NUM_SLOTS; s++)
    begin
      st          = '0;
      st.irs1_v   = one_in(2);
      st.irs2_v   = one_in(2);
      st.iwb_v    = one_in(2);
      st.fence_v  = one_in(10);
      st.mem_v    = one_in(4);
      st.csr_v    = one_in(10);
      st.long_v   = one_in(10);
      st.rs1_addr = rand_addr();
      st.rs2_addr = rand_addr();
      st.rd_addr  = rand_addr();
      isd_status[s] <= st;
      p            = '0;
      p.v          = one_in(2);
      p.late_iwb_v = one_in(6);
      p.mem_v      = one_in(4);
      p.csr_v      = one_in(10);
      p.irf_w_v    = one_in(2);
      p.pipe_class = pipe_class_e'($urandom_range(0, 6));
      p.rd_addr    = rand_addr();
      p.rs1_addr   = rand_addr();
      dispatch_pkt[s] <= p;
    end
    c.dcache_miss = one_in(8);
    c.opcode      = one_in(2) ? OPC_LOAD : (one_in(2) ? OPC_AMO : opcode_t'(7'h33));
    c.rd_addr     = rand_addr();
    commit_pkt    <= c;
    iwb_pkt       <= '{ird_w_v: one_in(3), late: !one_in(4), rd_addr: rand_addr()};
    cmd_full      <= one_in(10);
    credits_full  <= one_in(8);
    credits_empty <= !one_in(4);
    idiv_ready    <= !one_in(5);
    mem_ready     <= !one_in(6);
    ptw_busy      <= one_in(10);
    irq_pending   <= one_in(2);
  endtask

  initial
  begin
    void'($urandom(91101));
    checks        = 0;
    dispatch_errs = 0;
    irq_errs      = 0;
    directed_errs = 0;
    reset_i       = 1'b1;
    isd_status    = '0;
    dispatch_pkt  = '0;
    commit_pkt    = '0;
    iwb_pkt       = '0;
    cmd_full      = 1'b0;
    credits_full  = 1'b0;
    credits_empty = 1'b1;
    idiv_ready    = 1'b1;
    mem_ready     = 1'b1;
    ptw_busy      = 1'b0;
    irq_pending   = 1'b0;
    repeat (3) @(posedge clk_i);
    reset_i     <= 1'b0;
    irq_pending <= 1'b1;
    expect_stall(0, 0);
    expect_stall(1, 0);
    // execute stage producers
    producer_blocks_reader(PIPE_MUL, 5'd9, 2);
    producer_blocks_reader(PIPE_FMEM, 5'd3, 2);
    producer_blocks_reader(PIPE_AUX, 5'd9, 1);
    producer_blocks_reader(PIPE_EMEM, 5'd14, 1);
    producer_blocks_reader(PIPE_INT, 5'd9, 0);
    producer_blocks_reader(PIPE_MUL, 5'd0, 0);
    late_write_blocks(1'b0, 5'd12);
    late_write_blocks(1'b1, 5'd17);
    // fence, csr and long-latency rules
    level_holds_slot(0, ctl_status(1'b1, 1'b0, 1'b0, 1'b0), BLK_CREDITS_PENDING);
    level_holds_slot(0, ctl_status(1'b1, 1'b0, 1'b0, 1'b0), BLK_MEM_BUSY);
    level_holds_slot(1, ctl_status(1'b0, 1'b1, 1'b0, 1'b0), BLK_CREDITS_FULL);
    level_holds_slot(0, ctl_status(1'b0, 1'b0, 1'b0, 1'b1), BLK_DIV_BUSY);
    pipe_drain_holds_slot(0, ctl_status(1'b1, 1'b0, 1'b0, 1'b0), 1'b1, 3);
    pipe_drain_holds_slot(0, ctl_status(1'b1, 1'b0, 1'b0, 1'b0), 1'b0, 0);
    pipe_drain_holds_slot(1, ctl_status(1'b0, 1'b0, 1'b1, 1'b0), 1'b0, 3);
    pipe_drain_holds_slot(0, ctl_status(1'b0, 1'b0, 1'b0, 1'b1), 1'b0, 3);
    // structural levels and the interrupt mask of the page walker
    level_holds_slot(0, ctl_status(1'b0, 1'b0, 1'b0, 1'b0), BLK_PTW_BUSY);
    level_holds_slot(1, ctl_status(1'b0, 1'b0, 1'b0, 1'b0), BLK_CMD_FULL);
    level_holds_slot(1, ctl_status(1'b0, 1'b1, 1'b0, 1'b0), BLK_MEM_BUSY);
    repeat (RANDOM_CYCLES)
    begin
      @(posedge clk_i);
      drive_random();
    end
    @(posedge clk_i);
    finish_run(1'b0);
  end

endmodule
